//--- build.f
+incdir+tests
src/fixpt_pkg.sv
src/drum_ctrl_pkg.sv
src/node_update.sv
src/column_store.sv
src/drum_column.sv
src/drum_array.sv
src/sweep_sequencer.sv
src/drum_top.sv
tests/tb_drum.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_drum
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: simulate clean

# Build, run, and succeed only when the pass line shows up
simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "^Verification passed$$"

clean:
	rm -rf $(OBJ_DIR)

//--- tests/drum_model.svh
`ifndef DRUM_MODEL_SVH
`define DRUM_MODEL_SVH

// Reference grid, indexed [column][row]
amp_t model_cur  [NUM_COLS][MAX_ROWS];
amp_t model_prev [NUM_COLS][MAX_ROWS];
int   model_rows;

// 2^-7 in 1.17
localparam amp_t MODEL_STEP = 18'sh00400;

function automatic int min_of(input int a, input int b);
	return (a < b) ? a : b;
endfunction

// 1.17 product, sign bit then bits 33..17
function automatic amp_t fixed_mul(input amp_t a, input amp_t b);
	logic signed [35:0] wide_a;
	logic signed [35:0] wide_b;
	logic signed [35:0] p;
	wide_a = a;
	wide_b = b;
	p = wide_a * wide_b;
	return {p[35], p[33:17]};
endfunction

// Pyramid, one step per node from the nearest edge
task automatic model_init(input int rows);
	int m;
	model_rows = rows;
	for (int c = 0; c < NUM_COLS; c++) begin
		for (int r = 0; r < rows; r++) begin
			m = min_of(min_of(c + 1, NUM_COLS - c), min_of(r + 1, rows - r));
			model_cur[c][r]  = amp_t'(m) * MODEL_STEP;
			model_prev[c][r] = model_cur[c][r];
		end
	end
endtask

// One time step over the whole grid
task automatic model_step(input amp_t rho);
	amp_t next_grid [NUM_COLS][MAX_ROWS];
	amp_t left;
	amp_t right;
	amp_t up;
	amp_t down;
	amp_t lap;
	amp_t inter;
	for (int c = 0; c < NUM_COLS; c++) begin
		for (int r = 0; r < model_rows; r++) begin
			left  = (c > 0) ? model_cur[c-1][r] : '0;
			right = (c < NUM_COLS - 1) ? model_cur[c+1][r] : '0;
			down  = (r > 0) ? model_cur[c][r-1] : '0;
			up    = (r < model_rows - 1) ? model_cur[c][r+1] : '0;
			lap   = left + right + up + down - (model_cur[c][r] <<< 2);
			inter = fixed_mul(lap, rho) + (model_cur[c][r] <<< 1) - model_prev[c][r]
				+ (model_prev[c][r] >>> 10);
			next_grid[c][r] = inter - (inter >>> 9);
		end
	end
	for (int c = 0; c < NUM_COLS; c++) begin
		for (int r = 0; r < model_rows; r++) begin
			model_prev[c][r] = model_cur[c][r];
			model_cur[c][r]  = next_grid[c][r];
		end
	end
endtask

function automatic amp_t model_center();
	return model_cur[NUM_COLS/2][model_rows/2];
endfunction

`endif

//--- tests/tb_drum.sv
`timescale 1ns/1ps
`default_nettype none

module tb_drum import fixpt_pkg::*, drum_ctrl_pkg::*;;

	localparam int NUM_COLS   = 8;
	localparam int MAX_ROWS   = 64;
	localparam int ROWS_A     = 16;
	localparam int ROWS_B     = 21;
	localparam int ROWS_C     = 12;
	localparam int WAIT_LIMIT = MAX_ROWS + 16;
	// 2^-4 in 1.17
	localparam amp_t RHO_BASE = 18'sh02000;

	// Per test (steps + 1) * (rows + 8) cycles, four times over
	localparam int WATCHDOG_NS = 4 * 20 * ((0 + 1) * (ROWS_A + 8) + (10 + 1) * (ROWS_A + 8)
		+ (2 + 1) * (ROWS_A + 8) + (5 + 1) * (ROWS_B + 8) + 3 * (5 + 1) * (ROWS_C + 8));

	logic      CLOCK_50;
	logic      reset;
	drum_cfg_t cfg;
	logic      restart;
	logic      sample_req;
	logic      sample_valid;
	sample_t   sample;

	integer seed;
	int     mismatch_count;
	int     missing_count;
	int     other_count;

	`include "drum_model.svh"

	drum_top #(
		.NUM_COLS(NUM_COLS),
		.MAX_ROWS(MAX_ROWS)
	) i_dut (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.cfg         (cfg),
		.restart     (restart),
		.sample_req  (sample_req),
		.sample_valid(sample_valid),
		.sample      (sample)
	);

	initial begin
		CLOCK_50 = 1'b0;
		forever #10 CLOCK_50 = ~CLOCK_50;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns with the tests still running", WATCHDOG_NS);
		$display("Verification failed");
		$finish;
	end

	////////////////////
	// Compare tasks

	task automatic check_amp(input string name, input amp_t got, input amp_t exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_step(input string name, input logic [15:0] got, input logic [15:0] exp);
		if (got !== exp) begin
			mismatch_count++;
			$display("MISMATCH %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_missing(input string name, input int limit);
		missing_count++;
		$display("No %s strobe seen within %0d cycles", name, limit);
	endtask

	////////////////////
	// Stimulus helpers

	task automatic wait_sample(input int limit, output sample_t s, output logic got);
		int cycles;
		got = 1'b0;
		s = '0;
		cycles = 0;
		while (!got && cycles < limit) begin
			@(negedge CLOCK_50);
			cycles++;
			if (sample_valid === 1'b1) begin
				got = 1'b1;
				s = sample;
			end
		end
		if (!got)
			report_missing("sample_valid", limit);
	endtask

	task automatic request_sample();
		@(negedge CLOCK_50);
		sample_req = 1'b1;
		@(negedge CLOCK_50);
		sample_req = 1'b0;
	endtask

	task automatic restart_solver(input row_t rows, input amp_t rho);
		@(negedge CLOCK_50);
		cfg.num_rows = rows;
		cfg.rho = rho;
		restart = 1'b1;
		@(negedge CLOCK_50);
		restart = 1'b0;
	endtask

	task automatic check_initial_sample();
		sample_t s;
		logic    got;
		wait_sample(WAIT_LIMIT, s, got);
		if (got) begin
			check_step("sample.step", s.step, 16'd0);
			check_amp("sample.amp", s.amp, model_center());
		end
	endtask

	task automatic run_step(input amp_t rho, input logic [15:0] exp_step);
		sample_t s;
		logic    got;
		request_sample();
		wait_sample(WAIT_LIMIT, s, got);
		model_step(rho);
		if (got) begin
			check_step("sample.step", s.step, exp_step);
			check_amp("sample.amp", s.amp, model_center());
		end
	endtask

	////////////////////
	// Directed tests

	task automatic first_sample_test();
		model_init(ROWS_A);
		check_initial_sample();
	endtask

	task automatic ten_steps_test();
		for (int k = 1; k <= 10; k++)
			run_step(RHO_BASE, 16'(k));
	endtask

	// Second pulse lands mid sweep and must be dropped
	task automatic ignored_request_test();
		sample_t s;
		logic    got;
		int      extra;
		extra = 0;
		request_sample();
		repeat (3) @(negedge CLOCK_50);
		sample_req = 1'b1;
		@(negedge CLOCK_50);
		sample_req = 1'b0;
		wait_sample(WAIT_LIMIT, s, got);
		model_step(RHO_BASE);
		if (got) begin
			check_step("sample.step", s.step, 16'd11);
			check_amp("sample.amp", s.amp, model_center());
		end
		repeat (ROWS_A + 8) begin
			@(negedge CLOCK_50);
			if (sample_valid === 1'b1)
				extra++;
		end
		if (extra != 0) begin
			other_count++;
			$display("Got %0d extra samples after a request sent while busy", extra);
		end
		run_step(RHO_BASE, 16'd12);
	endtask

	task automatic odd_rows_test();
		restart_solver(row_t'(ROWS_B), RHO_BASE);
		model_init(ROWS_B);
		check_initial_sample();
		for (int k = 1; k <= 5; k++)
			run_step(RHO_BASE, 16'(k));
	endtask

	task automatic random_rho_test();
		amp_t rho;
		for (int i = 0; i < 3; i++) begin
			// Positive and below 0.25
			rho = amp_t'($random(seed)) & 18'sh07fff;
			restart_solver(row_t'(ROWS_C), rho);
			model_init(ROWS_C);
			check_initial_sample();
			for (int k = 1; k <= 5; k++)
				run_step(rho, 16'(k));
		end
	endtask

	initial begin
		seed = 32'hb5da_03d7;
		mismatch_count = 0;
		missing_count = 0;
		other_count = 0;
		reset = 1'b1;
		restart = 1'b0;
		sample_req = 1'b0;
		cfg.num_rows = row_t'(ROWS_A);
		cfg.rho = RHO_BASE;
		repeat (4) @(negedge CLOCK_50);
		if (sample_valid !== 1'b0) begin
			other_count++;
			$display("sample_valid was not low while reset was held");
		end
		reset = 1'b0;

		first_sample_test();
		ten_steps_test();
		ignored_request_test();
		odd_rows_test();
		random_rho_test();

		$display("Errors: %0d mismatches, %0d missing strobes, %0d other",
			mismatch_count, missing_count, other_count);
		if (mismatch_count + missing_count + other_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- src/drum_top.sv
`timescale 1ns/1ps
`default_nettype none

module drum_top import fixpt_pkg::*, drum_ctrl_pkg::*; #(
	parameter int NUM_COLS = 8,
	parameter int MAX_ROWS = 64
) (
	input  logic      CLOCK_50,
	input  logic      reset,
	input  drum_cfg_t cfg,
	input  logic      restart,
	input  logic      sample_req,
	output logic      sample_valid,
	output sample_t   sample
);

	sweep_ctl_t ctl;
	amp_t       center_amp;

	sweep_sequencer #(
		.NUM_COLS(NUM_COLS),
		.MAX_ROWS(MAX_ROWS)
	) i_sequencer (
		.CLOCK_50    (CLOCK_50),
		.reset       (reset),
		.cfg         (cfg),
		.restart     (restart),
		.sample_req  (sample_req),
		.center_amp  (center_amp),
		.ctl         (ctl),
		.sample_valid(sample_valid),
		.sample      (sample)
	);

	drum_array #(
		.NUM_COLS(NUM_COLS),
		.MAX_ROWS(MAX_ROWS)
	) i_array (
		.CLOCK_50  (CLOCK_50),
		.reset     (reset),
		.ctl       (ctl),
		.center_amp(center_amp)
	);

endmodule

`default_nettype wire

//--- src/sweep_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module sweep_sequencer import fixpt_pkg::*, drum_ctrl_pkg::*; #(
	parameter int NUM_COLS = 8,
	parameter int MAX_ROWS = 64
) (
	input  logic       CLOCK_50,
	input  logic       reset,
	input  drum_cfg_t  cfg,
	input  logic       restart,
	input  logic       sample_req,
	input  amp_t       center_amp,
	output sweep_ctl_t ctl,
	output logic       sample_valid,
	output sample_t    sample
);

	seq_state_t  state;
	drum_cfg_t   cfg_q;
	row_t        row;
	row_t        rd_row;
	row_t        last_row;
	row_t        row_next;
	row_t        rd_row_next;
	logic [15:0] step;
	logic        done;

	// The centre tap needs a column on each side
	if (NUM_COLS < 2) begin : g_cols_check
		$error("sweep_sequencer needs at least two columns");
	end

	assign last_row    = cfg_q.num_rows - row_t'(1);
	assign row_next    = (row == last_row) ? '0 : row + row_t'(1);
	assign rd_row_next = (rd_row == last_row) ? '0 : rd_row + row_t'(1);

	// Last row of init or of a sweep
	assign done = ((state == ST_INIT) || (state == ST_SWEEP)) && (row == last_row);

	////////////////////
	// Step FSM

	always_ff @(posedge CLOCK_50) begin
		if (reset || restart) begin
			state        <= ST_RESET;
			cfg_q        <= cfg;
			row          <= '0;
			rd_row       <= '0;
			step         <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= done;
			case (state)
				ST_RESET: begin
					state <= ST_INIT;
				end
				ST_INIT: begin
					row <= row_next;
					if (row == last_row) begin
						state <= ST_WAIT;
					end
				end
				ST_WAIT: begin
					if (sample_req) begin
						state <= ST_PRIME;
					end
				end
				ST_PRIME: begin
					// Rows 0 and 1 are in flight after two cycles
					rd_row <= rd_row_next;
					if (rd_row == row_t'(1)) begin
						state <= ST_SWEEP;
					end
				end
				ST_SWEEP: begin
					row    <= row_next;
					rd_row <= rd_row_next;
					if (row == last_row) begin
						state  <= ST_WAIT;
						rd_row <= '0;
						step   <= step + 16'd1;
					end
				end
				default: begin
					state <= ST_RESET;
				end
			endcase
		end
	end

	// Sample payload, centre value is already registered by the last row
	always_ff @(posedge CLOCK_50) begin
		if (done) begin
			sample.amp  <= center_amp;
			sample.step <= (state == ST_SWEEP) ? step + 16'd1 : step;
		end
	end

	always_comb begin
		ctl.init_en   = (state == ST_INIT);
		ctl.sweep_en  = (state == ST_SWEEP);
		ctl.first_row = (state == ST_SWEEP) && (row == '0);
		ctl.row       = row;
		ctl.rd_row    = rd_row;
		ctl.load      = (state == ST_SWEEP) || ((state == ST_PRIME) && (rd_row == row_t'(1)));
		ctl.num_rows  = cfg_q.num_rows;
		ctl.rho       = cfg_q.rho;
	end

	////////////////////
	// Checks

	// Row count latched on reset or restart must suit the pipeline and memories
	assert property (@(posedge CLOCK_50) disable iff (reset)
		(state == ST_RESET) |->
			(cfg_q.num_rows >= row_t'(3)) && (cfg_q.num_rows <= row_t'(MAX_ROWS)));

	assert property (@(posedge CLOCK_50) disable iff (reset)
		sample_valid |=> !sample_valid);

endmodule

`default_nettype wire

//--- src/drum_array.sv
`timescale 1ns/1ps
`default_nettype none

module drum_array import fixpt_pkg::*, drum_ctrl_pkg::*; #(
	parameter int NUM_COLS = 8,
	parameter int MAX_ROWS = 64
) (
	input  logic       CLOCK_50,
	input  logic       reset,
	input  sweep_ctl_t ctl,
	output amp_t       center_amp
);

	localparam int CENTER_COL = NUM_COLS / 2;

	amp_t u_here [NUM_COLS];
	amp_t u_new  [NUM_COLS];
	logic center_row;

	if (NUM_COLS % 2 != 0) begin : g_even_check
		$error("drum_array needs an even column count");
	end

	for (genvar c = 0; c < NUM_COLS; c++) begin : g_col
		amp_t u_left;
		amp_t u_right;

		// Fixed edges outside the grid
		if (c == 0) begin : g_left_edge
			assign u_left = '0;
		end else begin : g_left
			assign u_left = u_here[c-1];
		end

		if (c == NUM_COLS - 1) begin : g_right_edge
			assign u_right = '0;
		end else begin : g_right
			assign u_right = u_here[c+1];
		end

		drum_column #(
			.MAX_ROWS(MAX_ROWS),
			.COL     (c),
			.NUM_COLS(NUM_COLS)
		) i_column (
			.CLOCK_50(CLOCK_50),
			.reset   (reset),
			.ctl     (ctl),
			.u_left  (u_left),
			.u_right (u_right),
			.u_here  (u_here[c]),
			.u_new   (u_new[c])
		);
	end

	// Centre tap, row num_rows/2
	assign center_row = (ctl.init_en || ctl.sweep_en) && (ctl.row == (ctl.num_rows >> 1));

	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			center_amp <= '0;
		end else if (center_row) begin
			center_amp <= u_new[CENTER_COL];
		end
	end

endmodule

`default_nettype wire

//--- src/drum_column.sv
`timescale 1ns/1ps
`default_nettype none

module drum_column import fixpt_pkg::*, drum_ctrl_pkg::*; #(
	parameter int MAX_ROWS = 64,
	parameter int COL      = 0,
	parameter int NUM_COLS = 8
) (
	input  logic       CLOCK_50,
	input  logic       reset,
	input  sweep_ctl_t ctl,
	input  amp_t       u_left,
	input  amp_t       u_right,
	output amp_t       u_here,
	output amp_t       u_new
);

	// Distance to the nearer side edge, counted from one
	localparam int COL_EDGE = (COL + 1 < NUM_COLS - COL) ? COL + 1 : NUM_COLS - COL;

	amp_t rd_cur;
	amp_t rd_prev;
	amp_t cur_q;
	amp_t prev_q;
	amp_t down_q;
	amp_t u_up;
	amp_t u_down;
	amp_t u_next;
	amp_t init_val;
	amp_t wr_cur;
	amp_t wr_prev;
	row_t row_lo;
	row_t row_hi;
	row_t row_edge;
	row_t min_edge;
	logic last_row;
	logic we;

	////////////////////
	// Pyramid start value

	assign row_lo   = ctl.row + row_t'(1);
	assign row_hi   = ctl.num_rows - ctl.row;
	assign row_edge = (row_lo < row_hi) ? row_lo : row_hi;
	assign min_edge = (row_edge < row_t'(COL_EDGE)) ? row_edge : row_t'(COL_EDGE);
	assign init_val = amp_t'({8'd0, min_edge}) * STEP_SIZE;

	////////////////////
	// Sweep datapath

	// Read port already holds the row above
	assign last_row = (ctl.row == ctl.num_rows - row_t'(1));
	assign u_up     = last_row ? '0 : rd_cur;
	assign u_down   = ctl.first_row ? '0 : down_q;

	node_update i_node (
		.rho    (ctl.rho),
		.u_cur  (cur_q),
		.u_prev (prev_q),
		.u_left (u_left),
		.u_right(u_right),
		.u_up   (u_up),
		.u_down (u_down),
		.u_next (u_next)
	);

	// Shift one row up each sweep cycle
	always_ff @(posedge CLOCK_50) begin
		if (reset) begin
			cur_q  <= '0;
			prev_q <= '0;
			down_q <= '0;
		end else begin
			if (ctl.load) begin
				cur_q  <= rd_cur;
				prev_q <= rd_prev;
			end
			if (ctl.sweep_en) begin
				down_q <= cur_q;
			end
		end
	end

	// Init fills both grids alike, sweep retires the old value
	assign we      = ctl.init_en || ctl.sweep_en;
	assign wr_cur  = ctl.init_en ? init_val : u_next;
	assign wr_prev = ctl.init_en ? init_val : cur_q;

	column_store #(
		.MAX_ROWS(MAX_ROWS)
	) i_store (
		.CLOCK_50(CLOCK_50),
		.we      (we),
		.wr_row  (ctl.row),
		.rd_row  (ctl.rd_row),
		.wr_cur  (wr_cur),
		.wr_prev (wr_prev),
		.rd_cur  (rd_cur),
		.rd_prev (rd_prev)
	);

	assign u_here = cur_q;
	assign u_new  = wr_cur;

endmodule

`default_nettype wire

//--- src/column_store.sv
`timescale 1ns/1ps
`default_nettype none

module column_store import fixpt_pkg::*, drum_ctrl_pkg::*; #(
	parameter int MAX_ROWS = 64
) (
	input  logic CLOCK_50,
	input  logic we,
	input  row_t wr_row,
	input  row_t rd_row,
	input  amp_t wr_cur,
	input  amp_t wr_prev,
	output amp_t rd_cur,
	output amp_t rd_prev
);

	localparam int AW = (MAX_ROWS > 1) ? $clog2(MAX_ROWS) : 1;

	amp_t cur_mem  [MAX_ROWS];
	amp_t prev_mem [MAX_ROWS];

	// Read data is the old word on a same-row write
	always_ff @(posedge CLOCK_50) begin
		if (we) begin
			cur_mem[wr_row[AW-1:0]]  <= wr_cur;
			prev_mem[wr_row[AW-1:0]] <= wr_prev;
		end
		rd_cur  <= cur_mem[rd_row[AW-1:0]];
		rd_prev <= prev_mem[rd_row[AW-1:0]];
	end

	assert property (@(posedge CLOCK_50) we |-> (wr_row < row_t'(MAX_ROWS)));

endmodule

`default_nettype wire

//--- src/node_update.sv
`timescale 1ns/1ps
`default_nettype none

module node_update import fixpt_pkg::*; (
	input  amp_t rho,
	input  amp_t u_cur,
	input  amp_t u_prev,
	input  amp_t u_left,
	input  amp_t u_right,
	input  amp_t u_up,
	input  amp_t u_down,
	output amp_t u_next
);

	amp_t lap;
	amp_t rho_lap;
	amp_t inter;

	// Discrete Laplacian, wraps at 18 bits
	assign lap = u_left + u_right + u_up + u_down - (u_cur <<< 2);

	assign rho_lap = mult_1_17(lap, rho);

	// Leapfrog step with a small pull on the previous value
	assign inter = rho_lap + (u_cur <<< 1) - u_prev + (u_prev >>> 10);

	// Overall damping
	assign u_next = inter - (inter >>> 9);

endmodule

`default_nettype wire

//--- src/drum_ctrl_pkg.sv
`default_nettype none

package drum_ctrl_pkg;

	import fixpt_pkg::*;

	typedef logic [9:0] row_t;

	typedef enum logic [2:0] {
		ST_RESET,
		ST_INIT,
		ST_PRIME,
		ST_SWEEP,
		ST_WAIT
	} seq_state_t;

	// Solver setup, sampled on reset and restart
	typedef struct packed {
		row_t num_rows;
		amp_t rho;
	} drum_cfg_t;

	// Broadcast to every column each cycle
	typedef struct packed {
		logic init_en;
		logic sweep_en;
		logic first_row;
		row_t row;
		row_t rd_row;
		logic load;
		row_t num_rows;
		amp_t rho;
	} sweep_ctl_t;

	// One audio sample per time step
	typedef struct packed {
		amp_t        amp;
		logic [15:0] step;
	} sample_t;

endpackage

`default_nettype wire

//--- src/fixpt_pkg.sv
`default_nettype none

package fixpt_pkg;

	// Node amplitude, 1.17 two's complement
	typedef logic signed [17:0] amp_t;

	// Pyramid slope, one eighth over 16
	localparam amp_t STEP_SIZE = 18'sh00400;

	////////////////////
	// Signed 1.17 multiply

	function automatic amp_t mult_1_17(input amp_t a, input amp_t b);
		logic signed [35:0] prod;
		prod = a * b;
		// Keep the sign, drop the duplicate integer bit
		return {prod[35], prod[33:17]};
	endfunction

endpackage

`default_nettype wire
